/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memSystemTb
FILELIST  = list.f
OBJDIR    = obj_dir
PASSTEXT  = Finished with no errors

.PHONY: simulate clean

# Status comes from grep, so a missing pass line fails the target
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASSTEXT)" > /dev/null

clean:
	rm -rf $(OBJDIR)

/* list.f */
src/memPkg.sv
src/cacheWay.sv
src/bankedMem.sv
src/cacheCtrl.sv
src/memSystem.sv
verification/memSystem_assert.sv
verification/memSystemTb.sv

/* src/bankedMem.sv */
// Four interleaved word banks with busy counters and a two-stage read register
`timescale 1ns/1ns
`default_nettype none

module bankedMem #(
    parameter int bankLatency = 4
) (
    input  logic            clk,
    input  logic            arstN,
    input  memPkg::bankReqT req,
    output logic [15:0]     rdData,
    output logic [3:0]      busy
);
    import memPkg::*;

    localparam int cntW      = $clog2(bankLatency + 1);
    localparam int bankBits  = $clog2(nBanks);
    localparam int bankWords = 2 ** 13;   // One word per block address

    // Contents start at zero
    logic [15:0] memArr [nBanks][bankWords] = '{default: '0};

    logic [cntW-1:0]     busyCnt [nBanks];
    logic [nBanks-1:0]   accept;
    logic [bankBits-1:0] bankSel;
    logic [12:0]         blockSel;
    logic                rdAccept;
    logic                wrAccept;
    logic [15:0]         rdStage;
    logic                stageValid;

    assign bankSel  = req.addr.memView.bank;
    assign blockSel = req.addr.memView.block;

    for (genvar b = 0; b < nBanks; b++) begin : gBank
        // A bank only takes an access while idle
        assign accept[b] = (req.rd | req.wr) && (bankSel == bankBits'(b))
                           && (busyCnt[b] == '0);
        assign busy[b]   = (busyCnt[b] != '0);

        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                busyCnt[b] <= '0;
            end else if (accept[b]) begin
                busyCnt[b] <= cntW'(bankLatency);
            end else if (busyCnt[b] != '0) begin
                busyCnt[b] <= busyCnt[b] - 1'b1;
            end
        end
    end

    assign rdAccept = req.rd & (|accept);
    assign wrAccept = req.wr & (|accept);

    // Array write and first read stage
    always_ff @(posedge clk) begin
        if (wrAccept) begin
            memArr[bankSel][blockSel] <= req.data;
        end
        if (rdAccept) begin
            rdStage <= memArr[bankSel][blockSel];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= rdAccept;
        end
    end

    // Second stage holds the word until the next read
    always_ff @(posedge clk) begin
        if (stageValid) begin
            rdData <= rdStage;
        end
    end

endmodule

`default_nettype wire

/* src/cacheCtrl.sv */
// Cache controller FSM with way combining, victim choice, block fill and write-through
`timescale 1ns/1ns
`default_nettype none

module cacheCtrl (
    input  logic            clk,
    input  logic            arstN,
    input  memPkg::memReqT  req,
    input  memPkg::wayRespT resp0,
    input  memPkg::wayRespT resp1,
    input  logic [15:0]     memData,
    input  logic [3:0]      memBusy,
    output memPkg::wayCmdT  cmd0,
    output memPkg::wayCmdT  cmd1,
    output memPkg::bankReqT memReq,
    output logic [15:0]     dataOut,
    output logic            done,
    output logic            stall,
    output logic            cacheHit,
    output logic            err
);
    import memPkg::*;

    localparam int cntW     = $clog2(blockWords);
    localparam int bankBits = $clog2(nBanks);

    ctrlStateT state;
    ctrlStateT nextState;

    logic [cntW-1:0]     fillCnt;    // Block word being fetched
    logic [bankBits-1:0] curBank;
    logic                victim;
    logic                fillWay;
    logic                pickWay;
    logic                fillSeen;   // This read needed a fill
    logic                hit0;
    logic                hit1;
    logic                anyHit;
    logic                isRead;
    logic                isWrite;
    logic                bankBusy;
    logic                lastWord;
    logic                readHit;
    logic                doneNext;
    logic                inCompare;
    logic                inFill;
    memAddrT             fetchAddr;

    assign isRead    = req.rd;
    assign isWrite   = req.wr;
    assign inCompare = (state == compare);
    assign inFill    = (state == fill);

    assign hit0   = resp0.hit & resp0.valid;
    assign hit1   = resp1.hit & resp1.valid;
    assign anyHit = hit0 | hit1;

    assign dataOut = hit1 ? resp1.data : resp0.data;

    // Invalid way first, then the victim bit
    assign pickWay = !resp0.valid ? 1'b0 : (!resp1.valid ? 1'b1 : victim);

    assign curBank  = (state == fetch) ? fillCnt : req.addr.memView.bank;
    assign bankBusy = memBusy[curBank];
    assign lastWord = (fillCnt == cntW'(blockWords - 1));

    assign readHit  = inCompare & isRead & anyHit;
    assign doneNext = readHit | ((state == writeMem) & ~bankBusy);

    always_comb begin
        nextState = state;
        unique case (state)
            idle:      if ((isRead | isWrite) && !done) nextState = compare;
            compare: begin
                if (isWrite) begin
                    nextState = writeMem;
                end else if (anyHit) begin
                    nextState = idle;
                end else begin
                    nextState = fetch;
                end
            end
            fetch:     if (!bankBusy) nextState = fetchWait;
            fetchWait: nextState = fill;   // Read data lands next cycle
            fill:      nextState = lastWord ? compare : fetch;
            writeMem:  if (!bankBusy) nextState = idle;
            default:   nextState = idle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= idle;
            fillCnt  <= '0;
            victim   <= 1'b0;
            fillWay  <= 1'b0;
            fillSeen <= 1'b0;
            done     <= 1'b0;
            cacheHit <= 1'b0;
        end else begin
            state    <= nextState;
            done     <= doneNext;
            cacheHit <= readHit & ~fillSeen;
            if (inCompare) begin
                fillCnt <= '0;
            end else if (inFill) begin
                fillCnt <= fillCnt + 1'b1;
            end
            if (inCompare && isRead && !anyHit) begin
                fillWay <= pickWay;   // Held for the whole block
            end
            if (state == idle) begin
                fillSeen <= 1'b0;
            end else if (inFill) begin
                fillSeen <= 1'b1;
            end
            victim <= victim ^ ((inCompare & isRead) | inFill);
        end
    end

    // Both ways share address and data
    always_comb begin
        cmd0.tag     = req.addr.cacheView.tag;
        cmd0.index   = req.addr.cacheView.index;
        cmd0.offset  = inFill ? {fillCnt, 1'b0} : req.addr.cacheView.offset;
        cmd0.data    = inCompare ? req.data : memData;
        cmd0.comp    = inCompare;
        cmd0.write   = (inFill & ~fillWay) | (inCompare & isWrite);
        cmd0.validIn = inFill & ~fillWay;
        cmd1         = cmd0;
        cmd1.write   = (inFill & fillWay) | (inCompare & isWrite);
        cmd1.validIn = inFill & fillWay;
    end

    // Word-aligned block address for fetches
    always_comb begin
        fetchAddr                 = req.addr;
        fetchAddr.memView.bank    = fillCnt;
        fetchAddr.memView.byteSel = 1'b0;
    end

    assign memReq.rd   = (state == fetch);
    assign memReq.wr   = (state == writeMem);
    assign memReq.addr = (state == fetch) ? fetchAddr : req.addr;
    assign memReq.data = req.data;

    assign stall = (state != idle);
    assign err   = req.addr.memView.byteSel & (isRead | isWrite);

endmodule

`default_nettype wire

/* src/cacheWay.sv */
// Cache way with tag, valid and data arrays and a tag compare
`timescale 1ns/1ns
`default_nettype none

module cacheWay (
    input  logic            clk,
    input  logic            arstN,
    input  memPkg::wayCmdT  cmd,
    output memPkg::wayRespT resp
);
    import memPkg::*;

    localparam int nLines   = 256;
    localparam int wordBits = $clog2(blockWords);

    logic [4:0]  tagArr  [nLines];
    logic [15:0] dataArr [nLines * blockWords];
    logic [nLines-1:0] validArr;

    logic [7+wordBits:0] dataIdx;
    logic                lineValid;
    logic                tagMatch;
    logic                fillLine;
    logic                storeData;

    // Word select ignores the byte bit of the offset
    assign dataIdx   = {cmd.index, cmd.offset[wordBits:1]};
    assign lineValid = validArr[cmd.index];
    assign tagMatch  = (tagArr[cmd.index] == cmd.tag);

    // Combinational read port
    assign resp.data  = dataArr[dataIdx];
    assign resp.hit   = tagMatch;
    assign resp.valid = lineValid;

    // Fill writes data, tag and valid unconditionally
    assign fillLine = cmd.write & ~cmd.comp;

    // Compare-write only lands on a valid matching line
    assign storeData = fillLine | (cmd.write & cmd.comp & tagMatch & lineValid);

    always_ff @(posedge clk) begin
        if (storeData) begin
            dataArr[dataIdx] <= cmd.data;
        end
        if (fillLine) begin
            tagArr[cmd.index] <= cmd.tag;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validArr <= '0;
        end else if (fillLine) begin
            validArr[cmd.index] <= cmd.validIn;
        end
    end

endmodule

`default_nettype wire

/* src/memPkg.sv */
// Shared types and constants of the memory subsystem
`default_nettype none

package memPkg;

    localparam int nBanks     = 4;   // Interleaved word banks
    localparam int blockWords = 4;   // Words per cache block

    // Address as seen by the cache
    typedef struct packed {
        logic [4:0] tag;
        logic [7:0] index;
        logic [2:0] offset;   // Byte offset in block
    } cacheViewT;

    // Address as seen by the banked memory
    typedef struct packed {
        logic [12:0] block;
        logic [1:0]  bank;
        logic        byteSel;  // Set on an unaligned access
    } memViewT;

    typedef union packed {
        cacheViewT cacheView;
        memViewT   memView;
    } memAddrT;

    // Processor request
    typedef struct packed {
        logic        rd;
        logic        wr;
        memAddrT     addr;
        logic [15:0] data;
    } memReqT;

    // Controller to one way
    typedef struct packed {
        logic [4:0]  tag;
        logic [7:0]  index;
        logic [2:0]  offset;
        logic [15:0] data;
        logic        comp;     // Compare mode
        logic        write;
        logic        validIn;
    } wayCmdT;

    typedef struct packed {
        logic [15:0] data;
        logic        hit;      // Tag match only
        logic        valid;
    } wayRespT;

    // Controller to banked memory
    typedef struct packed {
        logic        rd;
        logic        wr;
        memAddrT     addr;
        logic [15:0] data;
    } bankReqT;

    typedef enum logic [2:0] {
        idle,
        compare,
        fetch,
        fetchWait,
        fill,
        writeMem
    } ctrlStateT;

endpackage

`default_nettype wire

/* src/memSystem.sv */
// Memory subsystem top with two cache ways, the controller and banked memory
`timescale 1ns/1ns
`default_nettype none

module memSystem #(
    parameter int bankLatency = 4
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        Rd,
    input  logic        Wr,
    input  logic [15:0] Addr,
    input  logic [15:0] DataIn,
    output logic [15:0] DataOut,
    output logic        Done,
    output logic        Stall,
    output logic        CacheHit,
    output logic        err
);
    import memPkg::*;

    memReqT      procReq;
    wayCmdT      cmd0;
    wayCmdT      cmd1;
    wayRespT     resp0;
    wayRespT     resp1;
    bankReqT     memReq;
    logic [15:0] memData;
    logic [3:0]  memBusy;

    // Processor pins into one request word
    assign procReq.rd   = Rd;
    assign procReq.wr   = Wr;
    assign procReq.addr = Addr;
    assign procReq.data = DataIn;

    cacheCtrl ctrl (
        .clk(clk), .arstN(arstN), .req(procReq),
        .resp0(resp0), .resp1(resp1), .memData(memData), .memBusy(memBusy),
        .cmd0(cmd0), .cmd1(cmd1), .memReq(memReq), .dataOut(DataOut),
        .done(Done), .stall(Stall), .cacheHit(CacheHit), .err(err)
    );

    cacheWay w0 (.clk(clk), .arstN(arstN), .cmd(cmd0), .resp(resp0));
    cacheWay w1 (.clk(clk), .arstN(arstN), .cmd(cmd1), .resp(resp1));

    bankedMem #(.bankLatency(bankLatency)) mem (
        .clk(clk), .arstN(arstN), .req(memReq), .rdData(memData), .busy(memBusy)
    );

endmodule

`default_nettype wire

/* verification/memSystemStim.txt */
# Columns in hex: op (0 read, 1 write) addr data expData expHit expErr
# expData is only checked on reads
# Cold miss then hit on the same word
0 0010 0000 0000 0 0
0 0010 0000 0000 1 0
# Write to a cached word then read it back
1 0012 1234 0000 0 0
0 0012 0000 1234 1 0
# Write to an uncached block then read it from memory
1 0820 beef 0000 0 0
0 0820 0000 beef 0 0
0 0822 0000 0000 1 0
# Three tags on index 6, back-to-back writes to bank 0
1 1030 2222 0000 0 0
1 1830 3333 0000 0 0
1 2030 4444 0000 0 0
0 1030 0000 2222 0 0
0 1830 0000 3333 0 0
0 2030 0000 4444 0 0
0 1030 0000 2222 1 0
0 1830 0000 3333 0 0
0 1030 0000 2222 0 0
0 2030 0000 4444 1 0
# Odd addresses use the word address
0 1031 0000 2222 1 1
1 0013 5678 0000 0 1
0 0012 0000 5678 1 0
# Read right after a write to the same bank
1 0048 0a0a 0000 0 0
0 0048 0000 0a0a 0 0
1 004a 0b0b 0000 0 0
0 004a 0000 0b0b 1 0
0 0058 0000 0000 0 0

/* verification/memSystemTb.sv */
// Testbench for the memory subsystem with file-driven requests and result checks
`timescale 1ns/1ns
`default_nettype none

module memSystemTb;

    localparam int bankLatency  = 4;
    localparam int clkPeriod    = 100;
    localparam int resetCycles  = 10;
    localparam int cyclesPerReq = 16 * bankLatency + 20;   // Worst case per request
    localparam string stimPath  = "verification/memSystemStim.txt";

    // One request line of the stimulus file
    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] expData;
        logic        expHit;
        logic        expErr;
    } stimT;

    logic        clk    = 1'b0;
    logic        arstN  = 1'b0;
    logic        Rd     = 1'b0;
    logic        Wr     = 1'b0;
    logic [15:0] Addr   = '0;
    logic [15:0] DataIn = '0;
    logic [15:0] DataOut;
    logic        Done;
    logic        Stall;
    logic        CacheHit;
    logic        err;

    stimT reqQ[$];
    int   errCount   = 0;
    int   goodReqs   = 0;
    int   badReqs    = 0;
    bit   stimLoaded = 1'b0;

    memSystem #(.bankLatency(bankLatency)) dut (
        .clk(clk), .arstN(arstN), .Rd(Rd), .Wr(Wr), .Addr(Addr), .DataIn(DataIn),
        .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkEqual(input logic [15:0] actual, input logic [15:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            errCount++;
        end
    endtask

    // Skips blank lines and lines starting with #
    task automatic loadStim(output bit ok);
        int          fd;
        int          code;
        int          n;
        string       line;
        logic [15:0] opF;
        logic [15:0] addrF;
        logic [15:0] dataF;
        logic [15:0] expDataF;
        logic [15:0] hitF;
        logic [15:0] errF;
        stimT        entry;
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                opF, addrF, dataF, expDataF, hitF, errF);
                    if (n == 6) begin
                        entry.wr      = opF[0];
                        entry.addr    = addrF;
                        entry.data    = dataF;
                        entry.expData = expDataF;
                        entry.expHit  = hitF[0];
                        entry.expErr  = errF[0];
                        reqQ.push_back(entry);
                    end
                end
            end
            $fclose(fd);
            ok = (reqQ.size() > 0);
        end
    endtask

    // Called on a rising edge, returns on the edge that ends the Done cycle
    task automatic runRequest(input int num, input stimT s);
        int errsBefore;
        int waitCycles;
        errsBefore = errCount;
        waitCycles = 0;
        Rd     <= !s.wr;
        Wr     <= s.wr;
        Addr   <= s.addr;
        DataIn <= s.data;
        do begin
            @(negedge clk);
            waitCycles++;
            // Request is in progress from the compare cycle until Done
            if (!Done && waitCycles > 1) begin
                checkEqual(16'(Stall), 16'd1, $sformatf("request %0d Stall", num));
            end
        end while (!Done);
        if (!s.wr) begin
            checkEqual(DataOut, s.expData, $sformatf("request %0d DataOut", num));
        end
        checkEqual(16'(CacheHit), 16'(s.expHit), $sformatf("request %0d CacheHit", num));
        checkEqual(16'(err), 16'(s.expErr), $sformatf("request %0d err", num));
        @(posedge clk);
        if (errCount == errsBefore) begin
            goodReqs++;
        end else begin
            badReqs++;
        end
        $display("Request %0d %s addr %h: %s", num, s.wr ? "write" : "read",
                 s.addr, (errCount == errsBefore) ? "matched" : "mismatched");
    endtask

    task automatic runAll();
        int gap;
        int assertFails;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        foreach (reqQ[i]) begin
            gap = int'($urandom_range(3, 0));
            if (gap > 0) begin   // Idle cycles between requests
                Rd <= 1'b0;
                Wr <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            runRequest(i + 1, reqQ[i]);
        end
        Rd <= 1'b0;
        Wr <= 1'b0;
        assertFails = dut.checks.failCount;
        $display("Requests %0d, matched %0d, mismatched %0d, errors %0d, assertion errors %0d",
                 reqQ.size(), goodReqs, badReqs, errCount, assertFails);
        if (errCount == 0 && assertFails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        void'($urandom(32'h13f2));
        loadStim(ok);
        stimLoaded = 1'b1;
        if (!ok) begin
            $display("Could not read any request from %s", stimPath);
            $display("Finished with errors");
            $finish;
        end else begin
            runAll();
        end
    end

    // Limit scales with the number of requests
    initial begin
        longint limitNs;
        wait (stimLoaded);
        limitNs = (longint'(reqQ.size()) * cyclesPerReq + resetCycles) * clkPeriod;
        #(limitNs);
        $display("Timed out at %0t ns waiting for Done", $time);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/memSystem_assert.sv */
// Bound handshake and reset assertions for the memory subsystem top
`timescale 1ns/1ns
`default_nettype none

module handshakeChecks (
    input logic clk,
    input logic arstN,
    input logic Rd,
    input logic Wr,
    input logic Done,
    input logic Stall,
    input logic CacheHit,
    input logic err
);

    int failCount = 0;   // Failed assertions so far

    doneOneCycle: assert property (@(posedge clk) disable iff (!arstN) Done |=> !Done)
        else begin
            failCount++;
            $error("Done held high for more than one cycle");
        end

    doneNotStalled: assert property (@(posedge clk) disable iff (!arstN) Done |-> !Stall)
        else begin
            failCount++;
            $error("Stall high in the Done cycle");
        end

    rdWrExclusive: assert property (@(posedge clk) disable iff (!arstN) !(Rd && Wr))
        else begin
            failCount++;
            $error("Rd and Wr high together");
        end

    quietAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> !Done && !Stall && !CacheHit && !err)
        else begin
            failCount++;
            $error("Outputs not low after reset");
        end

endmodule

bind memSystem handshakeChecks checks (
    .clk(clk), .arstN(arstN), .Rd(Rd), .Wr(Wr),
    .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err)
);

`default_nettype wire
